// ==== src/riscvIsaPkg.sv ====
package riscvIsaPkg;

    typedef logic [31:0] wordT;   // data word, fixed by the isa
    typedef logic [31:0] addrT;   // byte address
    typedef logic [4:0] regIdxT;  // x0..x31

    typedef struct packed {
        logic [6:0] funct7;  // alt bit picks sub / sra
        regIdxT rs2;
        regIdxT rs1;
        logic [2:0] funct3;
        regIdxT rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;  // also holds shamt and funct7 for shifts
        regIdxT rs1;
        logic [2:0] funct3;
        regIdxT rd;
        logic [6:0] opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;  // imm[11:5]
        regIdxT rs2;
        regIdxT rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;  // imm[4:0]
        logic [6:0] opcode;
    } sTypeT;

    typedef struct packed {
        logic imm12;
        logic [5:0] imm10to5;
        regIdxT rs2;
        regIdxT rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic imm20;
        logic [9:0] imm10to1;
        logic imm11;
        logic [7:0] imm19to12;
        regIdxT rd;
        logic [6:0] opcode;
    } jTypeT;

    // one fetched word, read through whichever format the opcode implies
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        sTypeT sType;
        bTypeT bType;
        jTypeT jType;
    } instrT;

    localparam logic [6:0] OP_R = 7'b0110011;       // reg-reg alu
    localparam logic [6:0] OP_IMM = 7'b0010011;     // reg-imm alu
    localparam logic [6:0] OP_LOAD = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL = 7'b1101111;
    localparam logic [6:0] OP_JALR = 7'b1100111;

    localparam logic [6:0] F7_ALT = 7'b0100000;     // sub, sra, srai

    localparam logic [2:0] F3_ADD = 3'b000;  // add / sub / addi
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SR = 3'b101;   // srl / sra, split by funct7
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

endpackage

// ==== src/coreCtrlPkg.sv ====
package coreCtrlPkg;

    // alu operation codes
    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR = 4'd3,
        XOR = 4'd4,
        SLL = 4'd7,    // shift by rs2
        SRL = 4'd8,
        SRA = 4'd11,
        SRAI = 4'd12,  // shift by immediate shamt
        SLLI = 4'd13,
        SRLI = 4'd14
    } aluOpT;

    typedef enum logic [1:0] {
        PLUS4 = 2'd0,   // sequential
        TARGET = 2'd1,  // pc + imm
        REG = 2'd2      // (rs1 + imm) & ~1
    } pcSrcT;

    typedef enum logic [1:0] {
        ALU = 2'd0,
        MEM = 2'd1,
        LINK = 2'd2     // pc + 4
    } resultSrcT;

    typedef enum logic [2:0] {
        I = 3'd0,
        S = 3'd1,
        B = 3'd2,
        J = 3'd3
    } immSrcT;

    // load / store width taken straight from funct3
    typedef enum logic [2:0] {
        BYTE = 3'd0,
        HALF = 3'd1,
        WORD = 3'd2,
        BYTE_U = 3'd4,
        HALF_U = 3'd5
    } addrModeT;

endpackage

// ==== src/controlIf.sv ====
`timescale 1ns/1ps

interface controlIf;

    logic regWrite;                             // rd write enable
    coreCtrlPkg::aluOpT aluControl;
    logic aluSrc;                               // 1 = immediate as alu b
    logic memWrite;                             // store strobe
    coreCtrlPkg::pcSrcT pcSrc;
    coreCtrlPkg::resultSrcT resultSrc;
    coreCtrlPkg::immSrcT immSrc;
    coreCtrlPkg::addrModeT addressingControl;
    logic zero;                                 // alu result == 0, back to decoder

    modport decoder (
        output regWrite, aluControl, aluSrc, memWrite, pcSrc,
        output resultSrc, immSrc, addressingControl,
        input zero
    );

    modport datapath (
        input regWrite, aluControl, aluSrc, memWrite, pcSrc,
        input resultSrc, immSrc, addressingControl,
        output zero
    );

endinterface

// ==== src/control.sv ====
`timescale 1ns/1ps

module control (
    input riscvIsaPkg::instrT instr,  // fetched word
    controlIf.decoder ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic isBranch;                       // beq / bne in flight
    logic takeBranch;
    coreCtrlPkg::pcSrcT basePcSrc;        // pc source before branch resolution

    assign opcode = instr.rType.opcode;
    assign funct3 = instr.rType.funct3;
    assign funct7 = instr.rType.funct7;   // same bits as imm[11:5] in i-type

    // main decode; every output starts at zero so unknown opcodes do nothing
    always_comb begin
        ctrl.regWrite = 1'b0;
        ctrl.aluControl = coreCtrlPkg::ADD;
        ctrl.aluSrc = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.resultSrc = coreCtrlPkg::ALU;
        ctrl.immSrc = coreCtrlPkg::I;
        ctrl.addressingControl = coreCtrlPkg::BYTE;
        basePcSrc = coreCtrlPkg::PLUS4;
        isBranch = 1'b0;
        case (opcode)
            riscvIsaPkg::OP_R: begin
                ctrl.regWrite = 1'b1;
                case (funct3)
                    riscvIsaPkg::F3_ADD: ctrl.aluControl = (funct7 == riscvIsaPkg::F7_ALT) ?
                        coreCtrlPkg::SUB : coreCtrlPkg::ADD;
                    riscvIsaPkg::F3_SLL: ctrl.aluControl = coreCtrlPkg::SLL;
                    riscvIsaPkg::F3_XOR: ctrl.aluControl = coreCtrlPkg::XOR;
                    riscvIsaPkg::F3_SR: ctrl.aluControl = (funct7 == riscvIsaPkg::F7_ALT) ?
                        coreCtrlPkg::SRA : coreCtrlPkg::SRL;
                    riscvIsaPkg::F3_OR: ctrl.aluControl = coreCtrlPkg::OR;
                    riscvIsaPkg::F3_AND: ctrl.aluControl = coreCtrlPkg::AND;
                    default: ctrl.regWrite = 1'b0;  // slt/sltu not supported
                endcase
            end
            riscvIsaPkg::OP_IMM: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.immSrc = coreCtrlPkg::I;
                case (funct3)
                    riscvIsaPkg::F3_ADD: ctrl.aluControl = coreCtrlPkg::ADD;   // addi
                    riscvIsaPkg::F3_SLL: ctrl.aluControl = coreCtrlPkg::SLLI;
                    riscvIsaPkg::F3_XOR: ctrl.aluControl = coreCtrlPkg::XOR;   // xori
                    riscvIsaPkg::F3_SR: ctrl.aluControl = (funct7 == riscvIsaPkg::F7_ALT) ?
                        coreCtrlPkg::SRAI : coreCtrlPkg::SRLI;
                    riscvIsaPkg::F3_OR: ctrl.aluControl = coreCtrlPkg::OR;     // ori
                    riscvIsaPkg::F3_AND: ctrl.aluControl = coreCtrlPkg::AND;   // andi
                    default: ctrl.regWrite = 1'b0;  // slti/sltiu dropped
                endcase
            end
            riscvIsaPkg::OP_LOAD: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;                    // address = rs1 + imm
                ctrl.resultSrc = coreCtrlPkg::MEM;
                ctrl.addressingControl = coreCtrlPkg::addrModeT'(funct3);
            end
            riscvIsaPkg::OP_STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.immSrc = coreCtrlPkg::S;
                ctrl.addressingControl = coreCtrlPkg::addrModeT'(funct3);
            end
            riscvIsaPkg::OP_BRANCH: begin
                ctrl.immSrc = coreCtrlPkg::B;
                ctrl.aluControl = coreCtrlPkg::SUB;    // zero flags rs1 == rs2
                isBranch = 1'b1;
            end
            riscvIsaPkg::OP_JAL: begin
                ctrl.regWrite = 1'b1;
                ctrl.immSrc = coreCtrlPkg::J;
                ctrl.resultSrc = coreCtrlPkg::LINK;
                basePcSrc = coreCtrlPkg::TARGET;
            end
            riscvIsaPkg::OP_JALR: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;                    // alu forms rs1 + imm
                ctrl.immSrc = coreCtrlPkg::I;
                ctrl.resultSrc = coreCtrlPkg::LINK;
                basePcSrc = coreCtrlPkg::REG;
            end
            default: ;                                 // unknown opcode, no-op
        endcase
    end

    // branch resolution kept apart so zero never feeds back into aluControl
    always_comb begin
        takeBranch = 1'b0;
        if (isBranch) begin
            case (funct3)
                riscvIsaPkg::F3_BEQ: takeBranch = ctrl.zero;
                riscvIsaPkg::F3_BNE: takeBranch = !ctrl.zero;
                default: takeBranch = 1'b0;            // blt etc. fall through
            endcase
        end
        ctrl.pcSrc = takeBranch ? coreCtrlPkg::TARGET : basePcSrc;
    end

endmodule

// ==== src/registerFile.sv ====
`timescale 1ns/1ps

module registerFile #(
    parameter int REG_COUNT = 32  // 16 for rv32e
) (
    input logic clk,
    input logic rst,
    input riscvIsaPkg::regIdxT rs1,
    input riscvIsaPkg::regIdxT rs2,
    input riscvIsaPkg::regIdxT rd,
    input logic writeEnable,
    input riscvIsaPkg::wordT writeValue,
    output riscvIsaPkg::wordT rs1Value,
    output riscvIsaPkg::wordT rs2Value
);

    localparam int IDX_W = $clog2(REG_COUNT);

    riscvIsaPkg::wordT regs [REG_COUNT];

    // index exists in this register file
    function automatic logic inRange(input riscvIsaPkg::regIdxT idx);
        return {1'b0, idx} < 6'(REG_COUNT);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) regs[i] <= '0;  // whole file cleared
        end else if (writeEnable && rd != '0 && inRange(rd)) begin
            regs[rd[IDX_W-1:0]] <= writeValue;                  // x0 never written
        end
    end

    assign rs1Value = inRange(rs1) ? regs[rs1[IDX_W-1:0]] : '0;  // async read
    assign rs2Value = inRange(rs2) ? regs[rs2[IDX_W-1:0]] : '0;

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
    input coreCtrlPkg::aluOpT operation,
    input riscvIsaPkg::wordT a,       // rs1
    input riscvIsaPkg::wordT b,       // rs2 or immediate
    output riscvIsaPkg::wordT result,
    output logic zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // rs2[4:0] or imm[4:0]

    always_comb begin
        case (operation)
            coreCtrlPkg::ADD: result = a + b;
            coreCtrlPkg::SUB: result = a - b;
            coreCtrlPkg::AND: result = a & b;
            coreCtrlPkg::OR: result = a | b;
            coreCtrlPkg::XOR: result = a ^ b;
            coreCtrlPkg::SLL,
            coreCtrlPkg::SLLI: result = a << shamt;
            coreCtrlPkg::SRL,
            coreCtrlPkg::SRLI: result = a >> shamt;
            coreCtrlPkg::SRA,
            coreCtrlPkg::SRAI: result = $signed(a) >>> shamt;  // sign fill
            default: result = '0;
        endcase
    end

    // used by beq / bne after sub
    assign zero = (result == '0);

endmodule

// ==== src/execute.sv ====
`timescale 1ns/1ps

module execute #(
    parameter riscvIsaPkg::addrT RESET_VECTOR = '0
) (
    input logic clk,
    input logic rst,
    input riscvIsaPkg::instrT instr,
    controlIf.datapath ctrl,
    input riscvIsaPkg::wordT rs1Value,
    input riscvIsaPkg::wordT rs2Value,
    input riscvIsaPkg::wordT readData,   // data memory, same cycle
    output riscvIsaPkg::addrT pc,
    output riscvIsaPkg::wordT rdValue,   // write-back value
    output riscvIsaPkg::addrT dataAddr,
    output riscvIsaPkg::wordT writeData,
    output logic [3:0] byteEnable,
    output logic memWrite
);

    riscvIsaPkg::wordT imm;
    riscvIsaPkg::wordT aluB;
    riscvIsaPkg::wordT aluResult;
    riscvIsaPkg::wordT loadValue;
    riscvIsaPkg::wordT laneShifted;      // addressed byte moved to bit 0
    riscvIsaPkg::addrT pcPlus4;
    riscvIsaPkg::addrT pcTarget;
    riscvIsaPkg::addrT pcNext;
    logic [1:0] byteOff;

    // immediate extension by format
    always_comb begin
        case (ctrl.immSrc)
            coreCtrlPkg::I: imm = {{20{instr.iType.imm[11]}}, instr.iType.imm};
            coreCtrlPkg::S: imm = {{20{instr.sType.immHi[6]}}, instr.sType.immHi,
                                   instr.sType.immLo};
            coreCtrlPkg::B: imm = {{19{instr.bType.imm12}}, instr.bType.imm12,
                                   instr.bType.imm11, instr.bType.imm10to5,
                                   instr.bType.imm4to1, 1'b0};
            coreCtrlPkg::J: imm = {{11{instr.jType.imm20}}, instr.jType.imm20,
                                   instr.jType.imm19to12, instr.jType.imm11,
                                   instr.jType.imm10to1, 1'b0};
            default: imm = '0;
        endcase
    end

    assign aluB = ctrl.aluSrc ? imm : rs2Value;

    alu alu_i (
        .operation(ctrl.aluControl),
        .a(rs1Value),
        .b(aluB),
        .result(aluResult),
        .zero(ctrl.zero)                 // branch decision happens in control
    );

    // next pc
    assign pcPlus4 = pc + 32'd4;
    assign pcTarget = pc + imm;          // jal and taken branch

    always_comb begin
        case (ctrl.pcSrc)
            coreCtrlPkg::TARGET: pcNext = pcTarget;
            coreCtrlPkg::REG: pcNext = {aluResult[31:1], 1'b0};  // jalr clears bit 0
            default: pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) pc <= RESET_VECTOR;
        else pc <= pcNext;               // one instruction per edge
    end

    // data memory side
    assign dataAddr = aluResult;
    assign memWrite = ctrl.memWrite;
    assign byteOff = dataAddr[1:0];
    assign laneShifted = readData >> {byteOff, 3'b000};

    // load alignment and extension
    always_comb begin
        case (ctrl.addressingControl)
            coreCtrlPkg::BYTE: loadValue = {{24{laneShifted[7]}}, laneShifted[7:0]};
            coreCtrlPkg::HALF: loadValue = {{16{laneShifted[15]}}, laneShifted[15:0]};
            coreCtrlPkg::BYTE_U: loadValue = {24'd0, laneShifted[7:0]};
            coreCtrlPkg::HALF_U: loadValue = {16'd0, laneShifted[15:0]};
            default: loadValue = readData;   // lw
        endcase
    end

    // store data replicated across lanes, enables pick the lane
    always_comb begin
        case (ctrl.addressingControl)
            coreCtrlPkg::BYTE: begin
                writeData = {4{rs2Value[7:0]}};
                byteEnable = 4'b0001 << byteOff;
            end
            coreCtrlPkg::HALF: begin
                writeData = {2{rs2Value[15:0]}};
                byteEnable = dataAddr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                writeData = rs2Value;        // sw
                byteEnable = 4'b1111;
            end
        endcase
        if (!ctrl.memWrite) byteEnable = 4'b0000;  // no lanes outside stores
    end

    // write-back select
    always_comb begin
        case (ctrl.resultSrc)
            coreCtrlPkg::MEM: rdValue = loadValue;
            coreCtrlPkg::LINK: rdValue = pcPlus4;  // jal / jalr link
            default: rdValue = aluResult;
        endcase
    end

endmodule

// ==== src/riscvCore.sv ====
`timescale 1ns/1ps

module riscvCore #(
    parameter riscvIsaPkg::addrT RESET_VECTOR = '0,
    parameter int REG_COUNT = 32                    // 16 = rv32e, 32 = rv32i
) (
    input logic clk,
    input logic rst,
    input riscvIsaPkg::instrT instr,                // from instruction memory
    input riscvIsaPkg::wordT readData,              // from data memory
    output riscvIsaPkg::addrT instrAddr,
    output riscvIsaPkg::addrT dataAddr,
    output riscvIsaPkg::wordT writeData,
    output logic [3:0] byteEnable,
    output logic memWrite
);

    riscvIsaPkg::wordT rs1Value;
    riscvIsaPkg::wordT rs2Value;
    riscvIsaPkg::wordT rdValue;

    controlIf ctrlBus ();

    control control_i (
        .instr(instr),
        .ctrl(ctrlBus.decoder)
    );

    registerFile #(
        .REG_COUNT(REG_COUNT)
    ) registerFile_i (
        .clk(clk),
        .rst(rst),
        .rs1(instr.rType.rs1),
        .rs2(instr.rType.rs2),
        .rd(instr.rType.rd),
        .writeEnable(ctrlBus.regWrite),
        .writeValue(rdValue),
        .rs1Value(rs1Value),
        .rs2Value(rs2Value)
    );

    execute #(
        .RESET_VECTOR(RESET_VECTOR)
    ) execute_i (
        .clk(clk),
        .rst(rst),
        .instr(instr),
        .ctrl(ctrlBus.datapath),
        .rs1Value(rs1Value),
        .rs2Value(rs2Value),
        .readData(readData),
        .pc(instrAddr),                             // pc drives fetch directly
        .rdValue(rdValue),
        .dataAddr(dataAddr),
        .writeData(writeData),
        .byteEnable(byteEnable),
        .memWrite(memWrite)
    );

endmodule

// ==== verification/riscvCoreTb.sv ====
`timescale 1ns/1ps

module riscvCoreTb;

    logic clk;
    logic rst;
    riscvIsaPkg::instrT instr;
    riscvIsaPkg::wordT readData;
    riscvIsaPkg::addrT instrAddr;
    riscvIsaPkg::addrT dataAddr;
    riscvIsaPkg::wordT writeData;
    logic [3:0] byteEnable;
    logic memWrite;

    riscvIsaPkg::instrT imem [64];  // 256 byte program space
    riscvIsaPkg::wordT dmem [64];
    riscvIsaPkg::addrT pcTrace [$];  // pc of every retired instruction
    logic [3:0] laneTrace [$];       // byteEnable of every store
    logic [31:0] lfsr = 32'hfe84;
    int progIdx;

    riscvCore #(.RESET_VECTOR(32'h0), .REG_COUNT(32)) riscvCore_i (
        .clk(clk), .rst(rst), .instr(instr), .readData(readData),
        .instrAddr(instrAddr), .dataAddr(dataAddr), .writeData(writeData),
        .byteEnable(byteEnable), .memWrite(memWrite)
    );

    assign instr = imem[instrAddr[7:2]];     // combinational fetch
    assign readData = dmem[dataAddr[7:2]];   // combinational load

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // memory write and trace capture on the retiring edge
    always @(posedge clk) begin
        if (!rst) begin
            pcTrace.push_back(instrAddr);
            if (memWrite) begin
                laneTrace.push_back(byteEnable);
                for (int l = 0; l < 4; l++)
                    if (byteEnable[l]) dmem[dataAddr[7:2]][8*l +: 8] = writeData[8*l +: 8];
            end
        end
    end

    // galois lfsr stepped once per bit
    function automatic riscvIsaPkg::wordT randBits(input int n);
        riscvIsaPkg::wordT r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'ha3000000 : lfsr >> 1;
        end
        return r;
    endfunction

    function automatic riscvIsaPkg::instrT rFormat(input logic [6:0] f7, input int rs2, rs1,
                                                   input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), riscvIsaPkg::OP_R};
    endfunction

    function automatic riscvIsaPkg::instrT iFormat(input logic [11:0] imm, input int rs1,
                                                   input logic [2:0] f3, input int rd,
                                                   input logic [6:0] op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic riscvIsaPkg::instrT sFormat(input logic [11:0] imm, input int rs2, rs1,
                                                   input logic [2:0] f3);
        return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], riscvIsaPkg::OP_STORE};
    endfunction

    function automatic riscvIsaPkg::instrT bFormat(input logic [12:0] imm, input int rs2, rs1,
                                                   input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11],
                riscvIsaPkg::OP_BRANCH};
    endfunction

    function automatic riscvIsaPkg::instrT jFormat(input logic [20:0] imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), riscvIsaPkg::OP_JAL};
    endfunction

    function automatic riscvIsaPkg::instrT lwAt(input int rd, input int addr);
        return iFormat(12'(addr), 0, 3'd2, rd, riscvIsaPkg::OP_LOAD);
    endfunction

    function automatic riscvIsaPkg::instrT swAt(input int rs2, input int addr);
        return sFormat(12'(addr), rs2, 0, 3'd2);
    endfunction

    task automatic emit(input riscvIsaPkg::instrT w);
        imem[progIdx] = w;
        progIdx++;
    endtask

    task automatic clearMem();
        foreach (imem[i]) imem[i] = '0;  // zero word decodes as no-op
        foreach (dmem[i]) dmem[i] = '0;
        progIdx = 0;
    endtask

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input riscvIsaPkg::wordT expected,
                             input riscvIsaPkg::wordT actual);
        if (expected !== actual)
            failRun($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic checkAddr(input string name, input riscvIsaPkg::addrT expected,
                             input riscvIsaPkg::addrT actual);
        if (expected !== actual)
            failRun($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic checkLanes(input string name, input logic [3:0] expected,
                              input logic [3:0] actual);
        if (expected !== actual)
            failRun($sformatf("mismatch %s expected %b actual %b", name, expected, actual));
    endtask

    // reset for 5 cycles then retire a fixed number of instructions
    task automatic runProgram(input string name, input int cycles);
        @(posedge clk);
        #2 rst = 1'b1;
        for (int i = 0; i < 5; i++) @(posedge clk);
        pcTrace.delete();
        laneTrace.delete();
        #2 rst = 1'b0;
        checkAddr({name, " reset pc"}, 32'h0, instrAddr);
        for (int i = 0; i < cycles; i++) @(posedge clk);
        #2;
    endtask

    task automatic verifyPcTrace(input string name, input riscvIsaPkg::addrT exp [$]);
        if (pcTrace.size() < exp.size()) failRun({name, ": fewer instructions retired"});
        foreach (exp[i]) checkAddr($sformatf("%s pc%0d", name, i), exp[i], pcTrace[i]);
    endtask

    task automatic rTypeOps();
        logic [2:0] f3 [8] = '{0, 0, 1, 4, 6, 7, 5, 5};  // add sub sll xor or and srl sra
        riscvIsaPkg::wordT a;
        riscvIsaPkg::wordT b;
        riscvIsaPkg::wordT exp;
        clearMem();
        a = randBits(32) | 32'h80000000;  // negative so sra and srl differ
        b = randBits(32) | 32'h1;         // nonzero shift amount
        dmem[0] = a;
        dmem[1] = b;
        emit(lwAt(1, 0));
        emit(lwAt(2, 4));
        for (int k = 0; k < 8; k++) begin
            emit(rFormat((k == 1 || k == 7) ? 7'h20 : 7'h00, 2, 1, f3[k], 3));
            emit(swAt(3, 64 + 4 * k));
        end
        runProgram("rtype", 18);
        for (int k = 0; k < 8; k++) begin
            case (k)
                0: exp = a + b;
                1: exp = a - b;
                2: exp = a << b[4:0];
                3: exp = a ^ b;
                4: exp = a | b;
                5: exp = a & b;
                6: exp = a >> b[4:0];
                default: exp = $signed(a) >>> b[4:0];  // arithmetic shift
            endcase
            checkWord($sformatf("rtype op%0d", k), exp, dmem[16 + k]);
        end
    endtask

    task automatic immediateOps();
        logic [2:0] f3 [7] = '{0, 4, 6, 7, 1, 5, 5};  // addi xori ori andi slli srli srai
        logic [11:0] imm [7];
        riscvIsaPkg::wordT a;
        riscvIsaPkg::wordT sx;
        riscvIsaPkg::wordT exp;
        clearMem();
        a = randBits(32) | 32'h80000000;  // negative so srai and srli differ
        dmem[0] = a;
        emit(lwAt(1, 0));
        for (int k = 0; k < 7; k++) begin
            imm[k] = (k < 4) ? 12'(randBits(12))
                             : {(k == 6) ? 7'h20 : 7'h00, 5'(randBits(5)) | 5'd1};
            emit(iFormat(imm[k], 1, f3[k], 3, riscvIsaPkg::OP_IMM));
            emit(swAt(3, 64 + 4 * k));
        end
        emit(iFormat(12'd5, 1, 3'd0, 0, riscvIsaPkg::OP_IMM));  // addi x0 is discarded
        emit(swAt(0, 96));
        dmem[24] = 32'hdeadbeef;
        runProgram("immediate", 17);
        for (int k = 0; k < 7; k++) begin
            sx = {{20{imm[k][11]}}, imm[k]};
            case (k)
                0: exp = a + sx;
                1: exp = a ^ sx;
                2: exp = a | sx;
                3: exp = a & sx;
                4: exp = a << imm[k][4:0];
                5: exp = a >> imm[k][4:0];
                default: exp = $signed(a) >>> imm[k][4:0];
            endcase
            checkWord($sformatf("immediate op%0d", k), exp, dmem[16 + k]);
        end
        checkWord("immediate x0", 32'h0, dmem[24]);
    endtask

    task automatic loadStoreLanes();
        logic [3:0] lanes [6] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100};
        riscvIsaPkg::wordT w;
        clearMem();
        w = randBits(32) | 32'h80008000;  // sign bits set in the loaded lanes
        dmem[0] = w;
        emit(lwAt(1, 0));
        for (int off = 0; off < 4; off++) emit(sFormat(12'(64 + off), 1, 0, 3'd0));  // sb
        emit(sFormat(12'd72, 1, 0, 3'd1));  // sh low half
        emit(sFormat(12'd74, 1, 0, 3'd1));  // sh high half
        emit(iFormat(12'd3, 0, 3'd0, 2, riscvIsaPkg::OP_LOAD));  // lb byte 3
        emit(swAt(2, 80));
        emit(iFormat(12'd2, 0, 3'd1, 2, riscvIsaPkg::OP_LOAD));  // lh upper half
        emit(swAt(2, 84));
        emit(iFormat(12'd1, 0, 3'd4, 2, riscvIsaPkg::OP_LOAD));  // lbu byte 1
        emit(swAt(2, 88));
        emit(iFormat(12'd0, 0, 3'd5, 2, riscvIsaPkg::OP_LOAD));  // lhu lower half
        emit(swAt(2, 92));
        emit(lwAt(2, 0));
        emit(swAt(2, 96));
        runProgram("loadstore", 17);
        if (laneTrace.size() != 11) failRun("loadstore: wrong number of stores");
        foreach (lanes[i]) checkLanes($sformatf("loadstore lanes%0d", i), lanes[i], laneTrace[i]);
        checkWord("loadstore sb", {4{w[7:0]}}, dmem[16]);
        checkWord("loadstore sh", {2{w[15:0]}}, dmem[18]);
        checkWord("loadstore lb", {{24{w[31]}}, w[31:24]}, dmem[20]);
        checkWord("loadstore lh", {{16{w[31]}}, w[31:16]}, dmem[21]);
        checkWord("loadstore lbu", {24'd0, w[15:8]}, dmem[22]);
        checkWord("loadstore lhu", {16'd0, w[15:0]}, dmem[23]);
        checkWord("loadstore lw", w, dmem[24]);
    endtask

    task automatic branchPaths();
        riscvIsaPkg::wordT a;
        clearMem();
        a = randBits(32);
        dmem[0] = a;
        dmem[1] = a ^ 32'h1;
        emit(lwAt(1, 0));
        emit(lwAt(2, 0));                     // x2 equals x1
        emit(lwAt(3, 4));                     // x3 differs
        emit(iFormat(12'd1, 0, 3'd0, 4, riscvIsaPkg::OP_IMM));  // marker value
        emit(bFormat(13'd8, 2, 1, 3'd0));     // beq taken
        emit(swAt(4, 64));
        emit(bFormat(13'd8, 3, 1, 3'd0));     // beq not taken
        emit(swAt(4, 68));
        emit(bFormat(13'd8, 3, 1, 3'd1));     // bne taken
        emit(swAt(4, 72));
        emit(bFormat(13'd8, 2, 1, 3'd1));     // bne not taken
        emit(swAt(4, 76));
        runProgram("branch", 10);
        verifyPcTrace("branch", '{0, 4, 8, 12, 16, 24, 28, 32, 40, 44});
        checkWord("branch beq taken", 32'h0, dmem[16]);
        checkWord("branch beq fall", 32'h1, dmem[17]);
        checkWord("branch bne taken", 32'h0, dmem[18]);
        checkWord("branch bne fall", 32'h1, dmem[19]);
    endtask

    task automatic jumpLinks();
        clearMem();
        emit(jFormat(21'd8, 1));              // jal x1 to 8
        emit(swAt(1, 72));                    // skipped
        emit(swAt(1, 64));
        emit(iFormat(12'd25, 0, 3'd0, 2, riscvIsaPkg::OP_IMM));
        emit(iFormat(12'd0, 2, 3'd0, 3, riscvIsaPkg::OP_JALR));  // 25 lands on 24
        emit(swAt(2, 72));                    // skipped
        emit(swAt(3, 68));
        runProgram("jump", 5);
        verifyPcTrace("jump", '{0, 8, 12, 16, 24});
        checkWord("jump jal link", 32'h4, dmem[16]);
        checkWord("jump jalr link", 32'h14, dmem[17]);
        checkWord("jump skipped", 32'h0, dmem[18]);
    endtask

    task automatic unknownOpcode();
        clearMem();
        dmem[0] = randBits(32);
        emit(lwAt(1, 0));
        emit({20'habcde, 5'd1, 7'h7f});       // unknown opcode with rd = x1
        emit(32'h0);
        emit(swAt(1, 64));
        runProgram("unknown", 4);
        verifyPcTrace("unknown", '{0, 4, 8, 12});
        if (laneTrace.size() != 1) failRun("unknown: unknown opcode caused a store");
        checkWord("unknown x1", dmem[0], dmem[16]);
    endtask

    initial begin
        #200000;                              // hang guard
        failRun("timeout: simulation did not finish");
    end

    initial begin
        rst = 1'b1;
        clearMem();
        rTypeOps();
        immediateOps();
        loadStoreLanes();
        branchPaths();
        jumpLinks();
        unknownOpcode();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== build.f ====
src/riscvIsaPkg.sv
src/coreCtrlPkg.sv
src/controlIf.sv
src/control.sv
src/registerFile.sv
src/alu.sv
src/execute.sv
src/riscvCore.sv
verification/riscvCoreTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -f build.f --top-module riscvCoreTb -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
    exit 0
fi
exit 1
